// File: hw/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath widths.
`define DATA_WIDTH     32
`define ADDR_WIDTH     32
`define REG_ADDR_WIDTH 5
`define SHAMT_WIDTH    5

// queue depth and initial commit credits.
`define IQ_DEPTH       4
`define COMMIT_CREDITS 4

// multiplier pipeline with one slice per stage.
`define MUL_STAGES     5
`define MUL_SLICE      7

`endif

// File: hw/isa_pkg.sv
`include "core_params.svh"

package isa_pkg;

  typedef enum logic [6:0] {
    R         = 7'b0110011,
    IMMEDIATE = 7'b0010011,
    AUIPC     = 7'b0010111,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    BRANCH    = 7'b1100011,
    JAL       = 7'b1101111
  } opcode_t;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_MUL = 3'b000;

  localparam logic [6:0] F7_SUB = 7'b0100000;
  localparam logic [6:0] F7_MUL = 7'b0000001;

  typedef struct packed {
    logic [6:0]                 funct7;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_t                    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]                imm;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_t                    opcode;
  } i_fmt_t;

  // one word, two views.
  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r;
    i_fmt_t      i;
  } instruction_t;

endpackage

// File: hw/pipe_pkg.sv
`include "core_params.svh"

package pipe_pkg;

  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] pc;
    isa_pkg::instruction_t  instr;
  } fetch_t;

  typedef struct packed {
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic                       rs1_needed;
    logic                       rs2_needed;
    logic                       is_mul;
    logic                       is_alu;
    logic                       reg_wr_en;
  } hazard_ctrl_t;

  typedef struct packed {
    logic                       valid;
    logic [`ADDR_WIDTH-1:0]     pc;
    isa_pkg::instruction_t      op;
    logic [`DATA_WIDTH-1:0]     rs1_val;
    logic [`DATA_WIDTH-1:0]     rs2_val;
    logic [`DATA_WIDTH-1:0]     imm;
    logic [`SHAMT_WIDTH-1:0]    shamt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       reg_wr_en;
  } alu_issue_t;

  typedef struct packed {
    logic                       valid;
    logic [`ADDR_WIDTH-1:0]     pc;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       reg_wr_en;
    logic [`DATA_WIDTH-1:0]     multiplicand;
    logic [`DATA_WIDTH-1:0]     multiplier;
    logic [`DATA_WIDTH-1:0]     product;
  } mul_payload_t;

  typedef struct packed {
    logic                       valid;
    logic [`ADDR_WIDTH-1:0]     pc;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       reg_wr_en;
    logic [`DATA_WIDTH-1:0]     value;
  } result_t;

  typedef struct packed {
    logic [`ADDR_WIDTH-1:0]     pc;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`DATA_WIDTH-1:0]     value;
  } commit_t;

endpackage

// File: hw/instr_queue.sv
`timescale 1ns/1ps
`include "core_params.svh"

module instr_queue (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 push_i,
  input  var pipe_pkg::fetch_t push_data_i,
  input  logic                 pop_i,
  output logic                 head_valid_o,
  output var pipe_pkg::fetch_t head_o,
  output logic                 credit_o
);

  localparam int PTR_W = $clog2(`IQ_DEPTH);
  localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

  pipe_pkg::fetch_t mem [`IQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full         = count == CNT_W'(`IQ_DEPTH);
  assign head_valid_o = count != '0;
  assign head_o       = mem[rd_ptr];
  assign do_pop       = pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count    <= count + CNT_W'(push_i) - CNT_W'(do_pop);
      // one credit back per dequeued entry.
      credit_o <= do_pop;
    end
  end

  // a push into a full queue means the producer overspent its credits.
  a_no_overrun: assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> !full)
    else $error("instr_queue: push while full");

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
  input  logic                       wr_en_i,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [`DATA_WIDTH-1:0]     wr_data_i,
  output logic [`DATA_WIDTH-1:0]     rs1_data_o,
  output logic [`DATA_WIDTH-1:0]     rs2_data_o
);

  localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

  logic [`DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // x0 reads zero.
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        head_valid_i,
  input  var pipe_pkg::fetch_t                        head_i,
  input  logic [`DATA_WIDTH-1:0]                      rs1_data_i,
  input  logic [`DATA_WIDTH-1:0]                      rs2_data_i,
  input  var pipe_pkg::result_t                       alu_fwd_i,
  input  var pipe_pkg::result_t                       mul_fwd_i,
  input  var pipe_pkg::result_t                       wb_fwd_i,
  input  logic [`MUL_STAGES-2:0]                      mul_busy_valid_i,
  input  logic [`MUL_STAGES-2:0][`REG_ADDR_WIDTH-1:0] mul_busy_rd_i,
  input  logic                                        commit_credit_i,
  output logic                                        pop_o,
  output logic [`REG_ADDR_WIDTH-1:0]                  rs1_addr_o,
  output logic [`REG_ADDR_WIDTH-1:0]                  rs2_addr_o,
  output var pipe_pkg::alu_issue_t                    alu_issue_o,
  output var pipe_pkg::mul_payload_t                  mul_issue_o
);

  localparam int CRED_W = $clog2(`COMMIT_CREDITS + 1);

  isa_pkg::instruction_t   instr;
  pipe_pkg::hazard_ctrl_t  ctrl;
  logic [`DATA_WIDTH-1:0]  imm;
  logic [`SHAMT_WIDTH-1:0] shamt;
  logic [`DATA_WIDTH-1:0]  rs1_val;
  logic [`DATA_WIDTH-1:0]  rs2_val;
  logic                    busy_hit;
  logic                    supported;
  logic                    stall;
  logic                    issue;
  logic [CRED_W-1:0]       credits;

  assign instr = head_i.instr;

  // ##############################
  // decode
  // ##############################

  always_comb begin : decode_ctrl
    ctrl     = '0;
    ctrl.rs1 = instr.r.rs1;
    ctrl.rs2 = instr.r.rs2;
    case (instr.r.opcode)
      isa_pkg::R: begin
        ctrl.rs1_needed = 1'b1;
        ctrl.rs2_needed = 1'b1;
        ctrl.is_mul     = instr.r.funct7 == isa_pkg::F7_MUL &&
                          instr.r.funct3 == isa_pkg::F3_MUL;
        ctrl.is_alu     = instr.r.funct7 != isa_pkg::F7_MUL;
      end
      isa_pkg::IMMEDIATE: begin
        ctrl.rs1_needed = 1'b1;
        ctrl.is_alu     = 1'b1;
      end
      isa_pkg::AUIPC: begin
        ctrl.is_alu = 1'b1;
      end
      default: ;
    endcase
    // no write and no forwarding for x0.
    ctrl.reg_wr_en = (ctrl.is_alu || ctrl.is_mul) && instr.r.rd != '0;
  end

  always_comb begin : imm_gen
    case (instr.r.opcode)
      isa_pkg::IMMEDIATE: imm = {{(`DATA_WIDTH - 12){instr.i.imm[11]}}, instr.i.imm};
      isa_pkg::AUIPC:     imm = {instr.raw[31:12], 12'b0};
      default:            imm = '0;
    endcase
  end

  // shift amount sits in the rs2 field.
  assign shamt = instr.r.rs2;

  // ##############################
  // forwarding and hazards
  // ##############################

  function automatic logic [`DATA_WIDTH-1:0] fwd_value(
    input logic [`REG_ADDR_WIDTH-1:0] rs,
    input logic [`DATA_WIDTH-1:0]     rf_data,
    input pipe_pkg::result_t          alu,
    input pipe_pkg::result_t          mul,
    input pipe_pkg::result_t          wb
  );
    if (alu.valid && alu.reg_wr_en && alu.rd == rs) begin
      return alu.value;
    end
    if (mul.valid && mul.reg_wr_en && mul.rd == rs) begin
      return mul.value;
    end
    if (wb.valid && wb.reg_wr_en && wb.rd == rs) begin
      return wb.value;
    end
    return rf_data;
  endfunction

  assign rs1_val = fwd_value(ctrl.rs1, rs1_data_i, alu_fwd_i, mul_fwd_i, wb_fwd_i);
  assign rs2_val = fwd_value(ctrl.rs2, rs2_data_i, alu_fwd_i, mul_fwd_i, wb_fwd_i);

  // sources and rd against multiplies still in flight.
  always_comb begin : mul_hazard
    busy_hit = 1'b0;
    for (int k = 0; k < `MUL_STAGES - 1; k++) begin
      if (mul_busy_valid_i[k] && mul_busy_rd_i[k] != '0 &&
          ((ctrl.rs1_needed && ctrl.rs1 == mul_busy_rd_i[k]) ||
           (ctrl.rs2_needed && ctrl.rs2 == mul_busy_rd_i[k]) ||
           (ctrl.reg_wr_en && instr.r.rd == mul_busy_rd_i[k]))) begin
        busy_hit = 1'b1;
      end
    end
  end

  assign supported = ctrl.is_alu || ctrl.is_mul;

  // an ALU op next to the last busy stage would meet it in writeback.
  assign stall = busy_hit || (ctrl.is_alu && mul_busy_valid_i[`MUL_STAGES-2]) ||
                 credits == '0;

  assign issue = head_valid_i && supported && !stall;
  // unsupported opcodes leave without issue.
  assign pop_o = head_valid_i && (!supported || !stall);

  assign rs1_addr_o = ctrl.rs1;
  assign rs2_addr_o = ctrl.rs2;

  always_comb begin : issue_out
    alu_issue_o.valid     = issue && ctrl.is_alu;
    alu_issue_o.pc        = head_i.pc;
    alu_issue_o.op        = instr;
    alu_issue_o.rs1_val   = rs1_val;
    alu_issue_o.rs2_val   = rs2_val;
    alu_issue_o.imm       = imm;
    alu_issue_o.shamt     = shamt;
    alu_issue_o.rd        = instr.r.rd;
    alu_issue_o.reg_wr_en = ctrl.reg_wr_en;

    mul_issue_o.valid        = issue && ctrl.is_mul;
    mul_issue_o.pc           = head_i.pc;
    mul_issue_o.rd           = instr.r.rd;
    mul_issue_o.reg_wr_en    = ctrl.reg_wr_en;
    mul_issue_o.multiplicand = rs1_val;
    mul_issue_o.multiplier   = rs2_val;
    mul_issue_o.product      = '0;
  end

  // ##############################
  // commit credits
  // ##############################

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits <= CRED_W'(`COMMIT_CREDITS);
    end else begin
      credits <= credits - CRED_W'(issue) + CRED_W'(commit_credit_i);
    end
  end

  // the consumer never returns more credits than it was given.
  a_credit_bound: assert property (
    @(posedge clk_i) disable iff (reset_i) credits <= CRED_W'(`COMMIT_CREDITS))
    else $error("decode_stage: commit credit overflow");

endmodule

// File: hw/alu_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module alu_stage (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  var pipe_pkg::alu_issue_t issue_i,
  output var pipe_pkg::result_t    result_o
);

  isa_pkg::instruction_t  op;
  logic [`DATA_WIDTH-1:0] a;
  logic [`DATA_WIDTH-1:0] b;
  logic [`DATA_WIDTH-1:0] value;

  assign op = issue_i.op;
  assign a  = issue_i.rs1_val;
  assign b  = issue_i.rs2_val;

  always_comb begin : alu_op
    value = '0;
    case (op.r.opcode)
      isa_pkg::R: begin
        case (op.r.funct3)
          isa_pkg::F3_ADD: value = (op.r.funct7 == isa_pkg::F7_SUB) ? a - b : a + b;
          isa_pkg::F3_SLL: value = a << b[`SHAMT_WIDTH-1:0];
          isa_pkg::F3_XOR: value = a ^ b;
          isa_pkg::F3_SRL: value = a >> b[`SHAMT_WIDTH-1:0];
          isa_pkg::F3_OR:  value = a | b;
          isa_pkg::F3_AND: value = a & b;
          default: ;
        endcase
      end
      isa_pkg::IMMEDIATE: begin
        case (op.i.funct3)
          isa_pkg::F3_ADD: value = a + issue_i.imm;
          isa_pkg::F3_XOR: value = a ^ issue_i.imm;
          isa_pkg::F3_OR:  value = a | issue_i.imm;
          isa_pkg::F3_AND: value = a & issue_i.imm;
          isa_pkg::F3_SLL: value = a << issue_i.shamt;
          isa_pkg::F3_SRL: value = a >> issue_i.shamt;
          default: ;
        endcase
      end
      // upper immediate already shifted in decode.
      isa_pkg::AUIPC: value = `DATA_WIDTH'(issue_i.pc) + issue_i.imm;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    result_o.pc        <= issue_i.pc;
    result_o.rd        <= issue_i.rd;
    result_o.reg_wr_en <= issue_i.reg_wr_en;
    result_o.value     <= value;
    if (reset_i) begin
      result_o.valid <= 1'b0;
    end else begin
      result_o.valid <= issue_i.valid;
    end
  end

endmodule

// File: hw/mul_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module mul_stage #(
  parameter int STAGE_IDX = 0
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  var pipe_pkg::mul_payload_t in_i,
  output var pipe_pkg::mul_payload_t out_o
);

  localparam int LSB = STAGE_IDX * `MUL_SLICE;

  logic [`MUL_SLICE-1:0]  slice;
  logic [`DATA_WIDTH-1:0] partial;

  // top slice runs past bit 31 and fills with zeros.
  assign slice   = `MUL_SLICE'(in_i.multiplier >> LSB);
  assign partial = (in_i.multiplicand * `DATA_WIDTH'(slice)) << LSB;

  always_ff @(posedge clk_i) begin
    out_o.pc           <= in_i.pc;
    out_o.rd           <= in_i.rd;
    out_o.reg_wr_en    <= in_i.reg_wr_en;
    out_o.multiplicand <= in_i.multiplicand;
    out_o.multiplier   <= in_i.multiplier;
    out_o.product      <= in_i.product + partial;
    if (reset_i) begin
      out_o.valid <= 1'b0;
    end else begin
      out_o.valid <= in_i.valid;
    end
  end

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module writeback_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  var pipe_pkg::result_t alu_i,
  input  var pipe_pkg::result_t mul_i,
  output var pipe_pkg::result_t wb_o,
  output logic                  commit_valid_o,
  output var pipe_pkg::commit_t commit_o
);

  pipe_pkg::result_t sel;

  assign sel = mul_i.valid ? mul_i : alu_i;

  always_ff @(posedge clk_i) begin
    wb_o.pc        <= sel.pc;
    wb_o.rd        <= sel.rd;
    wb_o.reg_wr_en <= sel.reg_wr_en;
    wb_o.value     <= sel.value;
    if (reset_i) begin
      wb_o.valid <= 1'b0;
    end else begin
      wb_o.valid <= sel.valid;
    end
  end

  // every result commits, x0 writes too.
  assign commit_valid_o = wb_o.valid;
  assign commit_o.pc    = wb_o.pc;
  assign commit_o.rd    = wb_o.rd;
  assign commit_o.value = wb_o.value;

  // decode holds ALU issue while the multiplier tail is about to land.
  a_one_source: assert property (
    @(posedge clk_i) disable iff (reset_i) !(alu_i.valid && mul_i.valid))
    else $error("writeback_stage: ALU and multiplier results collide");

endmodule

// File: hw/core_top.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  var pipe_pkg::fetch_t  instr_i,
  input  logic                  commit_credit_i,
  output logic                  instr_credit_o,
  output logic                  commit_valid_o,
  output var pipe_pkg::commit_t commit_o
);

  pipe_pkg::fetch_t                            head;
  logic                                        head_valid;
  logic                                        pop;
  logic [`REG_ADDR_WIDTH-1:0]                  rs1_addr;
  logic [`REG_ADDR_WIDTH-1:0]                  rs2_addr;
  logic [`DATA_WIDTH-1:0]                      rs1_data;
  logic [`DATA_WIDTH-1:0]                      rs2_data;
  pipe_pkg::alu_issue_t                        alu_issue;
  pipe_pkg::result_t                           alu_res;
  pipe_pkg::result_t                           mul_res;
  pipe_pkg::result_t                           wb_res;
  pipe_pkg::mul_payload_t [`MUL_STAGES:0]      mul_chain;
  logic [`MUL_STAGES-2:0]                      mul_busy_valid;
  logic [`MUL_STAGES-2:0][`REG_ADDR_WIDTH-1:0] mul_busy_rd;

  instr_queue instr_queue_inst (
    .clk_i,
    .reset_i,
    .push_i       (instr_valid_i),
    .push_data_i  (instr_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_o     (instr_credit_o)
  );

  reg_file reg_file_inst (
    .clk_i,
    .reset_i,
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_en_i    (wb_res.valid && wb_res.reg_wr_en),
    .wr_addr_i  (wb_res.rd),
    .wr_data_i  (wb_res.value),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  decode_stage decode_stage_inst (
    .clk_i,
    .reset_i,
    .head_valid_i     (head_valid),
    .head_i           (head),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .alu_fwd_i        (alu_res),
    .mul_fwd_i        (mul_res),
    .wb_fwd_i         (wb_res),
    .mul_busy_valid_i (mul_busy_valid),
    .mul_busy_rd_i    (mul_busy_rd),
    .commit_credit_i,
    .pop_o            (pop),
    .rs1_addr_o       (rs1_addr),
    .rs2_addr_o       (rs2_addr),
    .alu_issue_o      (alu_issue),
    .mul_issue_o      (mul_chain[0])
  );

  alu_stage alu_stage_inst (
    .clk_i,
    .reset_i,
    .issue_i  (alu_issue),
    .result_o (alu_res)
  );

  // ##############################
  // multiplier pipeline
  // ##############################

  for (genvar g = 0; g < `MUL_STAGES; g++) begin : gen_mul
    mul_stage #(
      .STAGE_IDX (g)
    ) mul_stage_inst (
      .clk_i,
      .reset_i,
      .in_i  (mul_chain[g]),
      .out_o (mul_chain[g+1])
    );

    // stages still short of the last one block dependent issue.
    if (g < `MUL_STAGES - 1) begin : gen_busy
      assign mul_busy_valid[g] = mul_chain[g+1].valid;
      assign mul_busy_rd[g]    = mul_chain[g+1].rd;
    end
  end

  assign mul_res = '{
    valid:     mul_chain[`MUL_STAGES].valid,
    pc:        mul_chain[`MUL_STAGES].pc,
    rd:        mul_chain[`MUL_STAGES].rd,
    reg_wr_en: mul_chain[`MUL_STAGES].reg_wr_en,
    value:     mul_chain[`MUL_STAGES].product
  };

  writeback_stage writeback_stage_inst (
    .clk_i,
    .reset_i,
    .alu_i          (alu_res),
    .mul_i          (mul_res),
    .wb_o           (wb_res),
    .commit_valid_o,
    .commit_o
  );

endmodule

// File: sim/tb_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core;

  localparam logic [6:0] OP_R     = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_JAL   = 7'b1101111;
  localparam logic [6:0] F7_SUB   = 7'b0100000;
  localparam logic [6:0] F7_MUL   = 7'b0000001;

  logic              clk_i = 1'b0;
  logic              reset_i = 1'b1;
  logic              instr_valid_i = 1'b0;
  pipe_pkg::fetch_t  instr_i = '0;
  logic              commit_credit_i = 1'b0;
  logic              instr_credit_o;
  logic              commit_valid_o;
  pipe_pkg::commit_t commit_o;

  logic [31:0]      rng_state = 32'hc1ca;
  logic [31:0]      ref_regs [32];
  logic [31:0]      next_pc = 32'h1000;
  pipe_pkg::fetch_t send_q [$];
  logic [31:0]      exp_value [logic [31:0]];
  logic [4:0]       exp_rd [logic [31:0]];
  int               sent_at [logic [31:0]];
  int               cycle = 0;
  int               prod_credits = `IQ_DEPTH;
  int               sent = 0;
  int               credits_back = 0;
  int               commits_seen = 0;
  int               cons_pending = 0;
  int               last_latency = 0;
  logic             withhold = 1'b0;

  core_top core_top_inst (
    .clk_i,
    .reset_i,
    .instr_valid_i,
    .instr_i,
    .commit_credit_i,
    .instr_credit_o,
    .commit_valid_o,
    .commit_o
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // ##############################
  // helpers
  // ##############################

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s = %h, expected %h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(next_random() % 32'd25) + 5'd1;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_R};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OP_AUIPC};
  endfunction

  function automatic logic [31:0] rand_alu_op(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    logic [31:0] r;
    r = next_random();
    case (r % 32'd13)
      0:       return enc_r(7'h00, rs2, rs1, 3'b000, rd);
      1:       return enc_r(F7_SUB, rs2, rs1, 3'b000, rd);
      2:       return enc_r(7'h00, rs2, rs1, 3'b001, rd);
      3:       return enc_r(7'h00, rs2, rs1, 3'b100, rd);
      4:       return enc_r(7'h00, rs2, rs1, 3'b101, rd);
      5:       return enc_r(7'h00, rs2, rs1, 3'b110, rd);
      6:       return enc_r(7'h00, rs2, rs1, 3'b111, rd);
      7:       return enc_i(r[31:20], rs1, 3'b000, rd, OP_IMM);
      8:       return enc_i(r[31:20], rs1, 3'b100, rd, OP_IMM);
      9:       return enc_i(r[31:20], rs1, 3'b110, rd, OP_IMM);
      10:      return enc_i(r[31:20], rs1, 3'b111, rd, OP_IMM);
      11:      return enc_i({7'h00, r[24:20]}, rs1, 3'b001, rd, OP_IMM);
      default: return enc_i({7'h00, r[24:20]}, rs1, 3'b101, rd, OP_IMM);
    endcase
  endfunction

  // reference register model in program order.
  task automatic model_instr(input logic [31:0] pc, input logic [31:0] word);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] v;
    logic        known;
    rd    = word[11:7];
    f3    = word[14:12];
    a     = ref_regs[word[19:15]];
    b     = ref_regs[word[24:20]];
    imm   = {{20{word[31]}}, word[31:20]};
    v     = '0;
    known = 1'b1;
    if (word[6:0] == OP_R && word[31:25] == F7_MUL) begin
      known = f3 == 3'b000;
      v     = a * b;
    end else if (word[6:0] == OP_R) begin
      case (f3)
        3'b000:  v = (word[31:25] == F7_SUB) ? a - b : a + b;
        3'b001:  v = a << b[4:0];
        3'b100:  v = a ^ b;
        3'b101:  v = a >> b[4:0];
        3'b110:  v = a | b;
        3'b111:  v = a & b;
        default: known = 1'b0;
      endcase
    end else if (word[6:0] == OP_IMM) begin
      case (f3)
        3'b000:  v = a + imm;
        3'b001:  v = a << word[24:20];
        3'b100:  v = a ^ imm;
        3'b101:  v = a >> word[24:20];
        3'b110:  v = a | imm;
        3'b111:  v = a & imm;
        default: known = 1'b0;
      endcase
    end else if (word[6:0] == OP_AUIPC) begin
      v = pc + {word[31:12], 12'b0};
    end else begin
      known = 1'b0;
    end
    if (known) begin
      if (rd != 5'd0) begin
        ref_regs[rd] = v;
      end
      exp_value[pc] = v;
      exp_rd[pc]    = rd;
    end
  endtask

  task automatic send_instr(input logic [31:0] word);
    pipe_pkg::fetch_t f;
    f.pc        = next_pc;
    f.instr.raw = word;
    model_instr(next_pc, word);
    send_q.push_back(f);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic load_random(input logic [4:0] rd);
    logic [31:0] r;
    r = next_random();
    send_instr(enc_u(r[31:12], rd));
    send_instr(enc_i(r[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  task automatic wait_drain();
    while (send_q.size() != 0 || exp_value.num() != 0 || cons_pending != 0) begin
      @(posedge clk_i);
    end
  endtask

  // ##############################
  // producer and consumer
  // ##############################

  always @(negedge clk_i) begin : drive_and_monitor
    pipe_pkg::fetch_t f;
    if (instr_credit_o) begin
      prod_credits = prod_credits + 1;
      credits_back = credits_back + 1;
      if (credits_back > sent) begin
        abort_run("instr_credit_o pulsed with no instruction outstanding");
      end
    end
    if (commit_valid_o && !exp_value.exists(commit_o.pc)) begin
      abort_run($sformatf("unexpected commit at pc %h", commit_o.pc));
    end else begin
      if (commit_valid_o) begin
        check_equal("commit_o.rd", 32'(commit_o.rd), 32'(exp_rd[commit_o.pc]));
        check_equal("commit_o.value", commit_o.value, exp_value[commit_o.pc]);
        last_latency = cycle - sent_at[commit_o.pc];
        exp_value.delete(commit_o.pc);
        exp_rd.delete(commit_o.pc);
        commits_seen = commits_seen + 1;
        cons_pending = cons_pending + 1;
      end
      commit_credit_i <= 1'b0;
      if (!withhold && cons_pending > 0) begin
        commit_credit_i <= 1'b1;
        cons_pending = cons_pending - 1;
      end
      instr_valid_i <= 1'b0;
      if (send_q.size() > 0 && prod_credits > 0) begin
        f = send_q.pop_front();
        instr_i       <= f;
        instr_valid_i <= 1'b1;
        prod_credits = prod_credits - 1;
        sent         = sent + 1;
        sent_at[f.pc] = cycle;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    if (cycle > sent * 40 + 200) begin
      abort_run("timeout: the DUT stopped committing instructions");
    end
  end

  // ##############################
  // tests
  // ##############################

  task automatic test_alu_ops();
    logic [31:0] r;
    for (int i = 1; i <= 4; i++) begin
      load_random(5'(i));
    end
    for (int i = 0; i < 16; i++) begin
      send_instr(rand_alu_op(rand_reg(), rand_reg(), rand_reg()));
    end
    r = next_random();
    send_instr(enc_u(r[31:12], rand_reg()));
    // x0 write commits but does not stick.
    send_instr(enc_i(12'h04d, 5'd1, 3'b000, 5'd0, OP_IMM));
    send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd26));
    send_instr(enc_r(7'h00, 5'd2, 5'd0, 3'b110, 5'd27));
    wait_drain();
  endtask

  task automatic test_multiply();
    logic [4:0] rd;
    load_random(5'd1);
    load_random(5'd2);
    wait_drain();
    send_instr(enc_r(F7_MUL, 5'd2, 5'd1, 3'b000, 5'd3));
    wait_drain();
    // one cycle in the queue, then six from issue to commit.
    check_equal("mul commit latency", last_latency, 32'd7);
    for (int i = 0; i < 8; i++) begin
      rd = 5'(next_random() % 32'd8) + 5'd4;
      load_random(rd);
      send_instr(enc_r(F7_MUL, rd, rand_reg(), 3'b000, 5'(i) + 5'd20));
    end
    wait_drain();
  endtask

  task automatic test_dependences();
    send_instr(enc_i(12'h0a5, 5'd1, 3'b000, 5'd5, OP_IMM));
    send_instr(enc_r(7'h00, 5'd2, 5'd5, 3'b000, 5'd6));
    send_instr(enc_r(7'h00, 5'd5, 5'd6, 3'b100, 5'd7));
    // multiply results feeding ALU and multiply.
    send_instr(enc_r(F7_MUL, 5'd2, 5'd1, 3'b000, 5'd8));
    send_instr(enc_r(7'h00, 5'd1, 5'd8, 3'b000, 5'd9));
    send_instr(enc_r(F7_MUL, 5'd9, 5'd8, 3'b000, 5'd10));
    send_instr(enc_r(F7_SUB, 5'd10, 5'd9, 3'b000, 5'd11));
    // consumers two and three slots behind.
    send_instr(enc_i(12'h7ff, 5'd3, 3'b000, 5'd12, OP_IMM));
    send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd13));
    send_instr(enc_r(7'h00, 5'd12, 5'd4, 3'b111, 5'd14));
    send_instr(enc_r(7'h00, 5'd12, 5'd13, 3'b000, 5'd15));
    // same rd from MUL then ADDI.
    send_instr(enc_r(F7_MUL, 5'd4, 5'd3, 3'b000, 5'd16));
    send_instr(enc_i(12'h123, 5'd1, 3'b000, 5'd16, OP_IMM));
    send_instr(enc_r(7'h00, 5'd0, 5'd16, 3'b000, 5'd17));
    wait_drain();
  endtask

  task automatic test_backpressure();
    int base;
    base     = commits_seen;
    withhold = 1'b1;
    for (int i = 0; i < 8; i++) begin
      if (i % 3 == 0) begin
        send_instr(enc_r(F7_MUL, rand_reg(), rand_reg(), 3'b000, 5'(18 + i)));
      end else begin
        send_instr(rand_alu_op(5'(18 + i), rand_reg(), rand_reg()));
      end
    end
    repeat (40) @(posedge clk_i);
    check_equal("commits with credits withheld", commits_seen - base, `COMMIT_CREDITS);
    withhold = 1'b0;
    wait_drain();
    check_equal("commits after release", commits_seen - base, 32'd8);
  endtask

  task automatic test_input_credits();
    int base_sent;
    int base_back;
    base_sent = sent;
    base_back = credits_back;
    withhold  = 1'b1;
    // unsupported opcodes leave the queue without a commit.
    send_instr(enc_i(12'h010, 5'd1, 3'b010, 5'd5, OP_LOAD));
    send_instr({20'h12345, 5'd3, OP_JAL});
    for (int i = 0; i < 10; i++) begin
      send_instr(rand_alu_op(rand_reg(), rand_reg(), rand_reg()));
    end
    repeat (40) @(posedge clk_i);
    check_equal("outstanding instructions", sent - credits_back, `IQ_DEPTH);
    withhold = 1'b0;
    wait_drain();
    check_equal("instr_credit_o pulses", credits_back - base_back, sent - base_sent);
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_equal("commit_valid_o", 32'(commit_valid_o), 32'd0);
    check_equal("instr_credit_o", 32'(instr_credit_o), 32'd0);
    reset_i = 1'b0;
    @(posedge clk_i);
    test_alu_ops();
    test_multiply();
    test_dependences();
    test_backpressure();
    test_input_credits();
    $display("All checks passed");
    $finish;
  end

endmodule

// File: all.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/instr_queue.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/alu_stage.sv
hw/mul_stage.sv
hw/writeback_stage.sv
hw/core_top.sv
sim/tb_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_core -f all.f

./obj_dir/Vtb_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "simulation did not finish"
  exit 1
fi
echo "simulation PASSED"
